// ==== i2c_cfg_master.f ====
+incdir+.
i2c_cfg_pkg.sv
i2c_bit_timer.sv
i2c_frame_fsm.sv
i2c_cfg_progress.sv
i2c_cfg_master.sv
tb_clk_gen.sv
tb_i2c_slave.sv
tb_i2c_cfg_master.sv

// ==== tb_i2c_cfg_master.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "i2c_cfg_defines.svh"

module tb_i2c_cfg_master;

    localparam int N_WORDS      = 6;
    localparam int MAX_ROWS     = 2 * N_WORDS;
    localparam int FRAME_CLKS   = 40 * `I2C_CLK_DIV;   // generous frame length
    localparam int QUIET_FRAMES = 3;

    wire                            clk;
    wire                            rst_n;
    i2c_cfg_pkg::cfg_index_t        cfg_size;
    wire i2c_cfg_pkg::cfg_word_t    cfg_data;
    wire i2c_cfg_pkg::cfg_index_t   cfg_index;
    wire                            cfg_done;
    wire                            scl;
    wire                            sda;
    logic [1:0]                     refuse_slot;
    wire [15:0]                     frame_cnt;
    wire [15:0]                     start_cnt;
    wire [7:0]                      rx_dev;
    wire [7:0]                      rx_reg;
    wire [7:0]                      rx_data;
    wire [3:0]                      rx_bytes;

    // lookup table and the per-frame stimulus rows built from it
    i2c_cfg_pkg::cfg_word_t  word_rom  [N_WORDS];
    i2c_cfg_pkg::cfg_word_t  row_word  [MAX_ROWS];
    logic [1:0]              row_refuse [MAX_ROWS];
    i2c_cfg_pkg::cfg_index_t row_index [MAX_ROWS];   // index expected after the frame
    int                      n_rows;
    int                      cycle_cnt   = 0;
    int                      cycle_limit = 0;

    tb_clk_gen clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    i2c_cfg_master i2c_cfg_master_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_size  (cfg_size),
        .cfg_data  (cfg_data),
        .cfg_index (cfg_index),
        .cfg_done  (cfg_done),
        .scl       (scl),
        .sda       (sda)
    );

    tb_i2c_slave slave_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .scl         (scl),
        .sda         (sda),
        .refuse_slot (refuse_slot),
        .frame_cnt   (frame_cnt),
        .start_cnt   (start_cnt),
        .rx_dev      (rx_dev),
        .rx_reg      (rx_reg),
        .rx_data     (rx_data),
        .rx_bytes    (rx_bytes)
    );

    pullup (sda);

    assign cfg_data = (cfg_index < N_WORDS) ? word_rom[cfg_index] : '0;   // outside lookup

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
            $display("Result: FAILED");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    // one accepted row per word, some words refused once before it
    task automatic build_table();
        n_rows = 0;
        for (int w = 0; w < N_WORDS; w++) begin
            if ((w == 1) || ($urandom % 3 == 0)) begin
                row_word[n_rows]   = word_rom[w];
                row_refuse[n_rows] = 2'(1 + ($urandom % 3));   // slot 1 to 3
                row_index[n_rows]  = 8'(w);                    // index holds
                n_rows++;
            end
            row_word[n_rows]   = word_rom[w];
            row_refuse[n_rows] = 2'd0;
            row_index[n_rows]  = 8'(w + 1);
            n_rows++;
        end
    endtask

    // --------------------------------------------------
    // run limit
    // --------------------------------------------------
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: no result after %0d clock cycles", cycle_cnt);
            $display("Result: FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    // --------------------------------------------------
    // stimulus and checks
    // --------------------------------------------------
    initial begin
        int prev_frames;
        int prev_starts;

        void'($urandom(32'h1af3_8f85));
        word_rom[0] = 24'h42_01_80;
        word_rom[1] = 24'h42_12_05;
        word_rom[2] = 24'h78_3a_c3;
        word_rom[3] = 24'ha0_00_ff;
        word_rom[4] = 24'h43_55_aa;
        word_rom[5] = 24'h30_7f_01;
        build_table();
        cycle_limit = 10 + `I2C_SETTLE_CYCLES + (n_rows + QUIET_FRAMES) * FRAME_CLKS;
        cfg_size    = 8'(N_WORDS);
        refuse_slot = 2'd0;

        @(posedge rst_n);
        repeat (`I2C_SETTLE_CYCLES - 1) begin   // bus quiet while settling
            @(posedge clk);
            #1;
            check_value("scl while settling", scl, 1);
            check_value("sda while settling", sda, 1);
            check_value("cfg_index while settling", cfg_index, 0);
            check_value("cfg_done while settling", cfg_done, 0);
        end

        for (int r = 0; r < n_rows; r++) begin
            @(posedge clk);
            #1;
            refuse_slot = row_refuse[r];
            prev_frames = frame_cnt;
            prev_starts = start_cnt;
            while (frame_cnt == prev_frames) begin
                @(posedge clk);
                #1;
            end
            check_value("start count", start_cnt, prev_starts + 1);
            check_value("byte count", rx_bytes, 3);
            check_value("device byte", rx_dev, row_word[r][`I2C_DEV_MSB -: 8]);
            check_value("register byte", rx_reg, row_word[r][`I2C_REG_MSB -: 8]);
            check_value("data byte", rx_data, row_word[r][`I2C_DATA_MSB -: 8]);
            check_value("cfg_index", cfg_index, row_index[r]);
            check_value("cfg_done", cfg_done, row_index[r] == N_WORDS);
        end

        // table finished, bus must stay idle
        check_value("cfg_done at end", cfg_done, 1);
        check_value("cfg_index at end", cfg_index, N_WORDS);
        prev_starts = start_cnt;
        repeat (QUIET_FRAMES * FRAME_CLKS) @(posedge clk);
        #1;
        check_value("starts after done", start_cnt, prev_starts);
        check_value("scl after done", scl, 1);
        check_value("sda after done", sda, 1);

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_i2c_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "i2c_cfg_defines.svh"

module tb_i2c_slave (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         scl,
    inout  wire         sda,
    input  wire  [1:0]  refuse_slot,   // 0 acks all, 1 to 3 leaves that slot high
    output logic [15:0] frame_cnt,
    output logic [15:0] start_cnt,
    output logic [7:0]  rx_dev,
    output logic [7:0]  rx_reg,
    output logic [7:0]  rx_data,
    output logic [3:0]  rx_bytes
);

    localparam int ACK_DELAY = 3 * `I2C_CLK_DIV / 8;   // low samples before taking sda

    logic       scl_q;
    logic       sda_q;
    logic       in_frame;
    logic       ack_drive;
    logic [3:0] bit_idx;    // scl pulses in this byte, 8 is the ack slot
    logic [3:0] byte_cnt;
    logic [7:0] shift_in;
    logic [7:0] low_cnt;
    logic [7:0] rx_buf [3];

    assign sda = ack_drive ? 1'b0 : 1'bz;   // pull-down only

    // --------------------------------------------------
    // pins sampled mid clock, away from the master edges
    // --------------------------------------------------
    always @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            in_frame  <= 1'b0;
            ack_drive <= 1'b0;
            bit_idx   <= '0;
            byte_cnt  <= '0;
            shift_in  <= '0;
            low_cnt   <= '0;
            rx_buf[0] <= '0;
            rx_buf[1] <= '0;
            rx_buf[2] <= '0;
            frame_cnt <= '0;
            start_cnt <= '0;
            rx_dev    <= '0;
            rx_reg    <= '0;
            rx_data   <= '0;
            rx_bytes  <= '0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl_q && scl && sda_q && !sda) begin
                in_frame  <= 1'b1;   // start
                ack_drive <= 1'b0;
                bit_idx   <= '1;     // the start's own scl fall brings it to 0
                byte_cnt  <= '0;
                start_cnt <= start_cnt + 1'b1;
            end else if (scl_q && scl && !sda_q && sda) begin
                if (in_frame) begin
                    rx_dev    <= rx_buf[0];   // stop closes the frame
                    rx_reg    <= rx_buf[1];
                    rx_data   <= rx_buf[2];
                    rx_bytes  <= byte_cnt;
                    frame_cnt <= frame_cnt + 1'b1;
                end
                in_frame  <= 1'b0;
                ack_drive <= 1'b0;
            end else if (in_frame && !scl_q && scl) begin
                if (bit_idx < 4'd8) begin
                    shift_in <= {shift_in[6:0], sda};   // msb first
                end
            end else if (in_frame && scl_q && !scl) begin
                low_cnt <= 8'd1;
                if (bit_idx == 4'd8) begin
                    ack_drive <= 1'b0;   // end of ack slot
                    bit_idx   <= '0;
                    byte_cnt  <= byte_cnt + 1'b1;
                    if (byte_cnt < 4'd3) begin
                        rx_buf[byte_cnt[1:0]] <= shift_in;
                    end
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                end
            end else if (in_frame && !scl) begin
                low_cnt <= low_cnt + 1'b1;
                if ((bit_idx == 4'd8) && (low_cnt == 8'(ACK_DELAY - 1)) &&
                    ((byte_cnt + 4'd1) != {2'b00, refuse_slot})) begin
                    ack_drive <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;   // released just after an edge
    end

endmodule

`default_nettype wire

// ==== i2c_cfg_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_cfg_master (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire i2c_cfg_pkg::cfg_index_t cfg_size,
    input  wire i2c_cfg_pkg::cfg_word_t  cfg_data,
    output i2c_cfg_pkg::cfg_index_t    cfg_index,
    output logic                       cfg_done,
    output logic                       scl,
    inout  wire                        sda
);

    logic                      bus_ready;
    logic                      ctrl_clk;
    logic                      transfer_en;
    logic                      capture_en;
    i2c_cfg_pkg::frame_state_t state_next;
    logic                      frame_end;
    logic                      sda_out;
    logic                      sda_oe;
    logic                      sda_in;

    i2c_bit_timer bit_timer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_ready   (bus_ready),
        .ctrl_clk    (ctrl_clk),
        .transfer_en (transfer_en),
        .capture_en  (capture_en)
    );

    i2c_frame_fsm frame_fsm_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_ready   (bus_ready),
        .transfer_en (transfer_en),
        .ctrl_clk    (ctrl_clk),
        .cfg_index   (cfg_index),
        .cfg_size    (cfg_size),
        .cfg_data    (cfg_data),
        .state_next  (state_next),
        .frame_end   (frame_end),
        .scl         (scl),
        .sda_out     (sda_out),
        .sda_oe      (sda_oe)
    );

    i2c_cfg_progress progress_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .capture_en  (capture_en),
        .transfer_en (transfer_en),
        .state_next  (state_next),
        .frame_end   (frame_end),
        .sda_in      (sda_in),
        .cfg_size    (cfg_size),
        .cfg_index   (cfg_index),
        .cfg_done    (cfg_done)
    );

    // --------------------------------------------------
    // open-drain style data pin
    // --------------------------------------------------
    assign sda    = sda_oe ? sda_out : 1'bz;   // released for ack slots
    assign sda_in = sda;                       // pin read back

endmodule

`default_nettype wire

// ==== i2c_cfg_progress.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_cfg_progress (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          capture_en,
    input  wire                          transfer_en,
    input  wire i2c_cfg_pkg::frame_state_t state_next,
    input  wire                          frame_end,
    input  wire                          sda_in,
    input  wire i2c_cfg_pkg::cfg_index_t   cfg_size,
    output i2c_cfg_pkg::cfg_index_t      cfg_index,
    output logic                         cfg_done
);

    logic ack1;
    logic ack2;
    logic ack3;
    logic frame_ok;   // all three slots pulled low

    // --------------------------------------------------
    // ack capture, sampled mid scl high
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {ack1, ack2, ack3} <= 3'b111;
            frame_ok           <= 1'b0;
        end else if (capture_en) begin
            case (state_next)
                i2c_cfg_pkg::IDLE: begin
                    {ack1, ack2, ack3} <= 3'b111;   // clear between frames
                    frame_ok           <= 1'b0;
                end
                i2c_cfg_pkg::ACK1: ack1 <= sda_in;
                i2c_cfg_pkg::ACK2: ack2 <= sda_in;
                i2c_cfg_pkg::ACK3: ack3 <= sda_in;
                i2c_cfg_pkg::STOP: frame_ok <= !(ack1 || ack2 || ack3);
                default: ;
            endcase
        end
    end

    // --------------------------------------------------
    // table index, moves on the strobe that leaves STOP
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_index <= '0;
        end else if (transfer_en && frame_end && frame_ok) begin
            if (cfg_index < cfg_size) begin
                cfg_index <= cfg_index + 1'b1;
            end else begin
                cfg_index <= cfg_size;   // hold at the end
            end
        end
    end

    assign cfg_done = (cfg_index == cfg_size);

    index_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_index <= cfg_size);

endmodule

`default_nettype wire

// ==== i2c_frame_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "i2c_cfg_defines.svh"

module i2c_frame_fsm (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        bus_ready,
    input  wire                        transfer_en,
    input  wire                        ctrl_clk,
    input  wire i2c_cfg_pkg::cfg_index_t cfg_index,
    input  wire i2c_cfg_pkg::cfg_index_t cfg_size,
    input  wire i2c_cfg_pkg::cfg_word_t  cfg_data,
    output i2c_cfg_pkg::frame_state_t  state_next,
    output logic                       frame_end,
    output logic                       scl,
    output logic                       sda_out,
    output logic                       sda_oe
);

    localparam int BYTE_W = $bits(i2c_cfg_pkg::i2c_byte_t);
    localparam i2c_cfg_pkg::bit_count_t BYTE_BITS = 4'd8;

    i2c_cfg_pkg::frame_state_t state;
    i2c_cfg_pkg::bit_count_t   bit_cnt;
    i2c_cfg_pkg::i2c_byte_t    shift;
    logic                      scl_gated;

    // --------------------------------------------------
    // next state, only moves on a transfer strobe
    // --------------------------------------------------
    always_comb begin
        state_next = state;
        if (transfer_en) begin
            case (state)
                i2c_cfg_pkg::IDLE: begin
                    if (bus_ready && (cfg_index < cfg_size)) begin
                        state_next = i2c_cfg_pkg::START;   // words left to send
                    end
                end
                i2c_cfg_pkg::START:    state_next = i2c_cfg_pkg::DEV_ADDR;
                i2c_cfg_pkg::DEV_ADDR: begin
                    if (bit_cnt == BYTE_BITS) begin
                        state_next = i2c_cfg_pkg::ACK1;
                    end
                end
                i2c_cfg_pkg::ACK1:     state_next = i2c_cfg_pkg::REG_ADDR;
                i2c_cfg_pkg::REG_ADDR: begin
                    if (bit_cnt == BYTE_BITS) begin
                        state_next = i2c_cfg_pkg::ACK2;
                    end
                end
                i2c_cfg_pkg::ACK2:     state_next = i2c_cfg_pkg::REG_DATA;
                i2c_cfg_pkg::REG_DATA: begin
                    if (bit_cnt == BYTE_BITS) begin
                        state_next = i2c_cfg_pkg::ACK3;
                    end
                end
                i2c_cfg_pkg::ACK3:     state_next = i2c_cfg_pkg::STOP;
                i2c_cfg_pkg::STOP:     state_next = i2c_cfg_pkg::IDLE;
                default:               state_next = i2c_cfg_pkg::IDLE;
            endcase
        end
    end

    // --------------------------------------------------
    // state, bit count and data line level
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= i2c_cfg_pkg::IDLE;
            bit_cnt <= '0;
            sda_out <= 1'b1;
        end else if (transfer_en) begin
            state <= state_next;
            case (state_next)
                i2c_cfg_pkg::IDLE: begin
                    sda_out <= 1'b1;   // stop edge, scl already high
                    bit_cnt <= '0;
                end
                i2c_cfg_pkg::START: begin
                    sda_out <= 1'b0;   // start with scl high
                    bit_cnt <= '0;
                end
                i2c_cfg_pkg::DEV_ADDR,
                i2c_cfg_pkg::REG_ADDR,
                i2c_cfg_pkg::REG_DATA: begin
                    sda_out <= shift[BYTE_W-1];   // msb first
                    bit_cnt <= bit_cnt + 1'b1;
                end
                i2c_cfg_pkg::ACK1,
                i2c_cfg_pkg::ACK2,
                i2c_cfg_pkg::ACK3: begin
                    bit_cnt <= '0;
                end
                i2c_cfg_pkg::STOP: begin
                    sda_out <= 1'b0;   // stop setup
                end
                default: ;
            endcase
        end
    end

    // byte shifter, loaded one slot before each byte
    always_ff @(posedge clk) begin
        if (transfer_en) begin
            case (state_next)
                i2c_cfg_pkg::START: shift <= cfg_data[`I2C_DEV_MSB -: BYTE_W];
                i2c_cfg_pkg::ACK1:  shift <= cfg_data[`I2C_REG_MSB -: BYTE_W];
                i2c_cfg_pkg::ACK2:  shift <= cfg_data[`I2C_DATA_MSB -: BYTE_W];
                i2c_cfg_pkg::DEV_ADDR,
                i2c_cfg_pkg::REG_ADDR,
                i2c_cfg_pkg::REG_DATA: shift <= {shift[BYTE_W-2:0], 1'b0};
                default: ;
            endcase
        end
    end

    // --------------------------------------------------
    // pin control
    // --------------------------------------------------
    assign scl_gated = state inside {i2c_cfg_pkg::DEV_ADDR, i2c_cfg_pkg::ACK1,
                                     i2c_cfg_pkg::REG_ADDR, i2c_cfg_pkg::ACK2,
                                     i2c_cfg_pkg::REG_DATA, i2c_cfg_pkg::ACK3};

    assign scl       = scl_gated ? ctrl_clk : 1'b1;   // idle high otherwise
    assign sda_oe    = !(state inside {i2c_cfg_pkg::ACK1, i2c_cfg_pkg::ACK2,
                                       i2c_cfg_pkg::ACK3});
    assign frame_end = (state == i2c_cfg_pkg::STOP);

    // slave owns the line only in an ack slot
    sda_release_in_ack: assert property (@(posedge clk) disable iff (!rst_n)
        !sda_oe |-> (state inside {i2c_cfg_pkg::ACK1, i2c_cfg_pkg::ACK2,
                                   i2c_cfg_pkg::ACK3}));

endmodule

`default_nettype wire

// ==== i2c_bit_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "i2c_cfg_defines.svh"

module i2c_bit_timer (
    input  wire  clk,
    input  wire  rst_n,
    output logic bus_ready,
    output logic ctrl_clk,
    output logic transfer_en,
    output logic capture_en
);

    localparam int SETTLE_W = $clog2(`I2C_SETTLE_CYCLES);
    localparam int PHASE_W  = $clog2(`I2C_CLK_DIV);

    localparam logic [SETTLE_W-1:0] SETTLE_LAST = SETTLE_W'(`I2C_SETTLE_CYCLES - 1);
    localparam logic [PHASE_W-1:0]  PHASE_LAST  = PHASE_W'(`I2C_CLK_DIV - 1);
    localparam logic [PHASE_W-1:0]  SCL_RISE    = PHASE_W'(`I2C_CLK_DIV / 4 + 1);
    localparam logic [PHASE_W-1:0]  SCL_FALL    = PHASE_W'(3 * `I2C_CLK_DIV / 4 + 1);
    localparam logic [PHASE_W-1:0]  CAPTURE_PH  = PHASE_W'(`I2C_CLK_DIV / 2 - 1);

    logic [SETTLE_W-1:0] settle_cnt;
    logic [PHASE_W-1:0]  phase;

    // --------------------------------------------------
    // power-up settling
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            settle_cnt <= '0;
        end else if (settle_cnt != SETTLE_LAST) begin
            settle_cnt <= settle_cnt + 1'b1;   // stops at the top
        end
    end

    assign bus_ready = (settle_cnt == SETTLE_LAST);

    // --------------------------------------------------
    // bit period phase and derived strobes
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase       <= '0;
            ctrl_clk    <= 1'b0;
            transfer_en <= 1'b0;
            capture_en  <= 1'b0;
        end else if (bus_ready) begin
            phase       <= (phase == PHASE_LAST) ? '0 : phase + 1'b1;
            ctrl_clk    <= (phase >= SCL_RISE) && (phase < SCL_FALL);  // high mid period
            transfer_en <= (phase == '0);        // sda changes while scl low
            capture_en  <= (phase == CAPTURE_PH); // sample while scl high
        end else begin
            phase       <= '0;
            ctrl_clk    <= 1'b0;
            transfer_en <= 1'b0;
            capture_en  <= 1'b0;
        end
    end

    // launch and sample points must stay apart within a bit
    strobes_apart: assert property (@(posedge clk) disable iff (!rst_n)
        !(transfer_en && capture_en));

endmodule

`default_nettype wire

// ==== i2c_cfg_pkg.sv ====
`default_nettype none

`include "i2c_cfg_defines.svh"

package i2c_cfg_pkg;

    // --------------------------------------------------
    // widths with a meaning
    // --------------------------------------------------
    typedef logic [`I2C_DEV_MSB:0] cfg_word_t;   // {dev, reg, data}
    typedef logic [7:0]            cfg_index_t;  // table index and size
    typedef logic [7:0]            i2c_byte_t;   // one byte on the wire
    typedef logic [3:0]            bit_count_t;  // 0 to 8

    // --------------------------------------------------
    // write frame states
    // --------------------------------------------------
    typedef enum logic [3:0] {
        IDLE,
        START,
        DEV_ADDR,
        ACK1,
        REG_ADDR,
        ACK2,
        REG_DATA,
        ACK3,
        STOP
    } frame_state_t;

endpackage

`default_nettype wire

// ==== i2c_cfg_defines.svh ====
`ifndef I2C_CFG_DEFINES_SVH
`define I2C_CFG_DEFINES_SVH

// --------------------------------------------------
// bus timing
// --------------------------------------------------

// system clocks per I2C bit period
// a real build sets this to f_sys / f_scl
`define I2C_CLK_DIV 16

// clocks held idle after reset so the slaves can settle
// hardware needs about 1 ms worth of system clocks here
`define I2C_SETTLE_CYCLES 64

// --------------------------------------------------
// configuration word layout
// --------------------------------------------------

`define I2C_DEV_MSB 23   // device address incl. r/w bit
`define I2C_REG_MSB 15   // register address
`define I2C_DATA_MSB 7   // register data

`endif
